// ==== common/ising_cfg_pkg.sv ====
// ising config package: array sizes, derived widths and sequencer phases
package ising_cfg_pkg;

    // array geometry
    localparam int NUM_SPIN = 8;
    localparam int BITDATA = 4;
    localparam int PARALLELISM = 2;

    // number of J words; the same value addresses the h word
    localparam int HADDR = NUM_SPIN / PARALLELISM;

    // address and select widths
    localparam int J_ADDR_W = $clog2(HADDR);
    localparam int SEL_W = (PARALLELISM > 1) ? $clog2(PARALLELISM) : 1;

    // pulse and row counters
    localparam int CNT_W = 16;

    // one spin row of weights
    localparam int ROW_W = NUM_SPIN * BITDATA;

    // sequencer phases
    typedef enum logic [1:0] {
        CFG_IDLE,
        CFG_FETCH,
        CFG_WWL_HIGH,
        CFG_WWL_LOW
    } cfg_state_e;

endpackage

// ==== src/step_counter.sv ====
// step counter: loadable limit, restart, maxed flag and wrap pulse
module step_counter (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            en_i,
    input  logic                            load_i,
    input  logic [ising_cfg_pkg::CNT_W-1:0] d_i,
    input  logic                            recount_i,
    input  logic                            step_i,
    output logic [ising_cfg_pkg::CNT_W-1:0] q_o,
    output logic                            maxed_o,
    output logic                            wrap_o
);
    import ising_cfg_pkg::*;

    logic [CNT_W-1:0] limit_q;
    logic [CNT_W-1:0] last_cnt;

    // a zero limit behaves like a limit of one
    assign last_cnt = (limit_q == '0) ? '0 : limit_q - 1'b1;
    assign maxed_o = (q_o == last_cnt);
    assign wrap_o = en_i & step_i & maxed_o & ~recount_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            limit_q <= '0;
        end else if (load_i) begin
            limit_q <= d_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (en_i) begin
            if (recount_i) begin
                q_o <= '0;
            end else if (step_i) begin
                q_o <= maxed_o ? '0 : q_o + 1'b1;
            end
        end
    end

endmodule

// ==== src/weight_store.sv ====
// weight store: J word memory and h row with slice writes and registered reads
module weight_store (
    input  logic                                                 clk_i,
    input  logic                                                 rst_n_i,
    input  logic                                                 mem_we_i,
    input  logic [ising_cfg_pkg::J_ADDR_W:0]                     mem_addr_i,
    input  logic [ising_cfg_pkg::SEL_W-1:0]                      mem_slice_i,
    input  logic [ising_cfg_pkg::ROW_W-1:0]                      mem_wdata_i,
    input  logic                                                 j_ren_i,
    input  logic [ising_cfg_pkg::J_ADDR_W-1:0]                   j_raddr_i,
    output logic [ising_cfg_pkg::ROW_W*ising_cfg_pkg::PARALLELISM-1:0] j_rdata_o,
    input  logic                                                 h_ren_i,
    output logic [ising_cfg_pkg::ROW_W-1:0]                      h_rdata_o
);
    import ising_cfg_pkg::*;

    logic [ROW_W*PARALLELISM-1:0] j_mem [HADDR];
    logic [ROW_W-1:0] h_mem;
    logic h_sel;
    logic j_sel;

    // address HADDR is the h row, the slice is ignored there
    assign h_sel = (mem_addr_i == (J_ADDR_W+1)'(HADDR));
    assign j_sel = (mem_addr_i < (J_ADDR_W+1)'(HADDR));

    always_ff @(posedge clk_i) begin
        if (mem_we_i && j_sel) begin
            j_mem[mem_addr_i[J_ADDR_W-1:0]][mem_slice_i*ROW_W +: ROW_W] <= mem_wdata_i;
        end
        if (mem_we_i && h_sel) begin
            h_mem <= mem_wdata_i;
        end
    end

    // read data holds until the next strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            j_rdata_o <= '0;
        end else if (j_ren_i) begin
            j_rdata_o <= j_mem[j_raddr_i];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_rdata_o <= '0;
        end else if (h_ren_i) begin
            h_rdata_o <= h_mem;
        end
    end

endmodule

// ==== analog_cfg/analog_cfg.sv ====
// analog config sequencer: writes weight rows into the array via WWL/WBL pulses
module analog_cfg (
    input  logic                                                 clk_i,
    input  logic                                                 rst_n_i,
    input  logic                                                 en_i,
    input  logic                                                 cfg_load_i,
    input  logic [ising_cfg_pkg::CNT_W-1:0]                      cycle_per_wwl_high_i,
    input  logic [ising_cfg_pkg::CNT_W-1:0]                      cycle_per_wwl_low_i,
    input  logic                                                 bypass_conv_i,
    input  logic                                                 start_i,
    output logic                                                 j_ren_o,
    output logic [ising_cfg_pkg::J_ADDR_W-1:0]                   j_raddr_o,
    input  logic [ising_cfg_pkg::ROW_W*ising_cfg_pkg::PARALLELISM-1:0] j_rdata_i,
    output logic                                                 h_ren_o,
    input  logic [ising_cfg_pkg::ROW_W-1:0]                      h_rdata_i,
    output logic [ising_cfg_pkg::NUM_SPIN-1:0]                   j_wwl_o,
    output logic                                                 h_wwl_o,
    output logic [ising_cfg_pkg::ROW_W-1:0]                      wbl_o,
    output logic                                                 idle_o
);
    import ising_cfg_pkg::*;

    cfg_state_e state_q, state_d;
    logic fetch_ph_q;
    logic [SEL_W-1:0] slice_q;
    logic bypass_q;

    logic start_ok;
    logic high_step, low_step;
    logic high_maxed, low_maxed;
    logic row_step, row_maxed, seq_done;
    logic [CNT_W-1:0] row_q;
    logic on_h;
    logic more_rows;
    logic load_row;
    logic [J_ADDR_W+SEL_W-1:0] row_idx;
    logic [ROW_W-1:0] row_raw, row_conv;

    assign start_ok = en_i & start_i & (state_q == CFG_IDLE);
    assign high_step = (state_q == CFG_WWL_HIGH);
    assign low_step = (state_q == CFG_WWL_LOW);

    // last counter step is the h word
    assign on_h = row_maxed;
    assign more_rows = (slice_q != '0);
    assign row_step = low_step & low_maxed & ~more_rows;

    assign j_ren_o = (state_q == CFG_FETCH) & ~fetch_ph_q & ~on_h;
    assign h_ren_o = (state_q == CFG_FETCH) & ~fetch_ph_q & on_h;
    assign j_raddr_o = row_q[J_ADDR_W-1:0];
    assign idle_o = (state_q == CFG_IDLE);

    // new row at the end of a fetch or back-to-back within a word
    assign load_row = en_i & (((state_q == CFG_FETCH) & fetch_ph_q) |
                              (low_step & low_maxed & more_rows));

    // word address times PARALLELISM plus slice
    assign row_idx = {row_q[J_ADDR_W-1:0], slice_q};

    assign row_raw = on_h ? h_rdata_i : j_rdata_i[slice_q*ROW_W +: ROW_W];

    // macro format: inverted sign in bit 0, negated magnitude above
    always_comb begin
        for (int i = 0; i < NUM_SPIN; i++) begin
            row_conv[i*BITDATA] = ~row_raw[i*BITDATA+BITDATA-1];
            row_conv[i*BITDATA+1 +: BITDATA-1] = ~row_raw[i*BITDATA +: BITDATA-1] + 1'b1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            CFG_IDLE: begin
                if (start_i) begin
                    state_d = CFG_FETCH;
                end
            end
            CFG_FETCH: begin
                if (fetch_ph_q) begin
                    state_d = CFG_WWL_HIGH;
                end
            end
            CFG_WWL_HIGH: begin
                if (high_maxed) begin
                    state_d = CFG_WWL_LOW;
                end
            end
            CFG_WWL_LOW: begin
                if (low_maxed) begin
                    if (more_rows) begin
                        state_d = CFG_WWL_HIGH;
                    end else if (seq_done) begin
                        state_d = CFG_IDLE;
                    end else begin
                        state_d = CFG_FETCH;
                    end
                end
            end
            default: state_d = CFG_IDLE;
        endcase
        if (!en_i) begin
            state_d = CFG_IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= CFG_IDLE;
            fetch_ph_q <= 1'b0;
            slice_q <= '0;
        end else begin
            state_q <= state_d;
            fetch_ph_q <= en_i & (state_q == CFG_FETCH) & ~fetch_ph_q;
            if (!en_i || start_ok) begin
                slice_q <= '0;
            end else if (high_step && high_maxed && !on_h) begin
                slice_q <= (slice_q == SEL_W'(PARALLELISM-1)) ? '0 : slice_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bypass_q <= 1'b0;
        end else if (cfg_load_i) begin
            bypass_q <= bypass_conv_i;
        end
    end

    // word lines
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            j_wwl_o <= '0;
            h_wwl_o <= 1'b0;
        end else if (!en_i || (high_step && high_maxed)) begin
            j_wwl_o <= '0;
            h_wwl_o <= 1'b0;
        end else if (load_row) begin
            j_wwl_o <= on_h ? '0 : NUM_SPIN'(1) << row_idx;
            h_wwl_o <= on_h;
        end
    end

    // bit lines only move together with a rising word line
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wbl_o <= '0;
        end else if (load_row) begin
            wbl_o <= bypass_q ? row_raw : row_conv;
        end
    end

    step_counter i_wwl_high_counter (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .en_i      (en_i),
        .load_i    (cfg_load_i),
        .d_i       (cycle_per_wwl_high_i),
        .recount_i (start_ok),
        .step_i    (high_step),
        .q_o       (),
        .maxed_o   (high_maxed),
        .wrap_o    ()
    );

    step_counter i_wwl_low_counter (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .en_i      (en_i),
        .load_i    (cfg_load_i),
        .d_i       (cycle_per_wwl_low_i),
        .recount_i (start_ok),
        .step_i    (low_step),
        .q_o       (),
        .maxed_o   (low_maxed),
        .wrap_o    ()
    );

    // J words plus one h step
    step_counter i_row_counter (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .en_i      (en_i),
        .load_i    (cfg_load_i),
        .d_i       (CNT_W'(HADDR + 1)),
        .recount_i (start_ok),
        .step_i    (row_step),
        .q_o       (row_q),
        .maxed_o   (row_maxed),
        .wrap_o    (seq_done)
    );

endmodule

// ==== src/ising_cfg_top.sv ====
// ising config top: weight store feeding the analog write sequencer
module ising_cfg_top (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                mem_we_i,
    input  logic [ising_cfg_pkg::J_ADDR_W:0]    mem_addr_i,
    input  logic [ising_cfg_pkg::SEL_W-1:0]     mem_slice_i,
    input  logic [ising_cfg_pkg::ROW_W-1:0]     mem_wdata_i,
    input  logic                                cfg_load_i,
    input  logic [ising_cfg_pkg::CNT_W-1:0]     cycle_per_wwl_high_i,
    input  logic [ising_cfg_pkg::CNT_W-1:0]     cycle_per_wwl_low_i,
    input  logic                                bypass_conv_i,
    input  logic                                en_i,
    input  logic                                start_i,
    output logic [ising_cfg_pkg::NUM_SPIN-1:0]  j_wwl_o,
    output logic                                h_wwl_o,
    output logic [ising_cfg_pkg::ROW_W-1:0]     wbl_o,
    output logic                                idle_o
);
    import ising_cfg_pkg::*;

    logic j_ren;
    logic [J_ADDR_W-1:0] j_raddr;
    logic [ROW_W*PARALLELISM-1:0] j_rdata;
    logic h_ren;
    logic [ROW_W-1:0] h_rdata;

    weight_store i_weight_store (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mem_we_i    (mem_we_i),
        .mem_addr_i  (mem_addr_i),
        .mem_slice_i (mem_slice_i),
        .mem_wdata_i (mem_wdata_i),
        .j_ren_i     (j_ren),
        .j_raddr_i   (j_raddr),
        .j_rdata_o   (j_rdata),
        .h_ren_i     (h_ren),
        .h_rdata_o   (h_rdata)
    );

    analog_cfg i_analog_cfg (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .en_i                 (en_i),
        .cfg_load_i           (cfg_load_i),
        .cycle_per_wwl_high_i (cycle_per_wwl_high_i),
        .cycle_per_wwl_low_i  (cycle_per_wwl_low_i),
        .bypass_conv_i        (bypass_conv_i),
        .start_i              (start_i),
        .j_ren_o              (j_ren),
        .j_raddr_o            (j_raddr),
        .j_rdata_i            (j_rdata),
        .h_ren_o              (h_ren),
        .h_rdata_i            (h_rdata),
        .j_wwl_o              (j_wwl_o),
        .h_wwl_o              (h_wwl_o),
        .wbl_o                (wbl_o),
        .idle_o               (idle_o)
    );

endmodule

// ==== testbench/ising_cfg_assertions.sv ====
// bound checks on word-line exclusivity and bit-line stability
module ising_cfg_assertions (
    input logic                                clk_i,
    input logic                                rst_n_i,
    input logic [ising_cfg_pkg::NUM_SPIN-1:0]  j_wwl_o,
    input logic                                h_wwl_o,
    input logic [ising_cfg_pkg::ROW_W-1:0]     wbl_o,
    input logic                                idle_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic any_wwl;

    assign any_wwl = (|j_wwl_o) | h_wwl_o;

    a_onehot_j: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(j_wwl_o)) else $error("more than one J word line high");

    a_j_h_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((|j_wwl_o) && h_wwl_o)) else $error("J and h word lines high together");

    a_wbl_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        any_wwl && $past(any_wwl) |-> $stable(wbl_o))
        else $error("bit lines moved under a word line");

    a_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        any_wwl |-> !idle_o) else $error("idle while a word line is high");

endmodule

bind analog_cfg ising_cfg_assertions u_ising_cfg_assertions (.*);

// ==== testbench/tb_ising_cfg.sv ====
// trace-driven testbench for weight loads, configuration and write pulses
module tb_ising_cfg;
    timeunit 1ns;
    timeprecision 100ps;
    import ising_cfg_pkg::*;

    logic clk_i;
    logic rst_n_i;
    logic mem_we_i;
    logic [J_ADDR_W:0] mem_addr_i;
    logic [SEL_W-1:0] mem_slice_i;
    logic [ROW_W-1:0] mem_wdata_i;
    logic cfg_load_i;
    logic [CNT_W-1:0] cycle_per_wwl_high_i;
    logic [CNT_W-1:0] cycle_per_wwl_low_i;
    logic bypass_conv_i;
    logic en_i;
    logic start_i;
    logic [NUM_SPIN-1:0] j_wwl_o;
    logic h_wwl_o;
    logic [ROW_W-1:0] wbl_o;
    logic idle_o;

    // expected rows with the h word at index NUM_SPIN
    logic [ROW_W-1:0] exp_conv [NUM_SPIN+1];
    logic [ROW_W-1:0] exp_raw [NUM_SPIN+1];
    int budget = 100;
    int cycles = 0;

    ising_cfg_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // watchdog budget grows with every sequence started
    initial begin
        while (cycles <= budget) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("watchdog expired: the DUT did not finish within %0d cycles", budget);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic reject_trace_line(input string kind);
        $display("the trace file has a malformed %s line", kind);
        $display("TESTS FAILED");
        $fatal(1, "bad trace");
    endtask

    task automatic write_word(input int addr, input int slice, input logic [ROW_W-1:0] data);
        @(posedge clk_i);
        mem_we_i <= 1'b1;
        mem_addr_i <= (J_ADDR_W+1)'(addr);
        mem_slice_i <= SEL_W'(slice);
        mem_wdata_i <= data;
        @(posedge clk_i);
        mem_we_i <= 1'b0;
        budget += 2;
    endtask

    // one full write sequence that stops early when row abort_row rises
    task automatic run_sequence(input string name, input int h, input int l,
                                input int byp, input int abort_row);
        int hi;
        int gap;
        @(posedge clk_i);
        cycle_per_wwl_high_i <= CNT_W'(h);
        cycle_per_wwl_low_i <= CNT_W'(l);
        bypass_conv_i <= byp[0];
        cfg_load_i <= 1'b1;
        en_i <= 1'b1;
        @(posedge clk_i);
        cfg_load_i <= 1'b0;
        start_i <= 1'b1;
        @(posedge clk_i);
        start_i <= 1'b0;
        budget += (NUM_SPIN + 1) * (h + l + 2) + 10;
        for (int r = 0; r <= NUM_SPIN; r++) begin
            while (j_wwl_o == '0 && !h_wwl_o) @(negedge clk_i);
            compare_value({name, "_wwl"}, 32'(1) << r, {h_wwl_o, j_wwl_o});
            compare_value({name, "_wbl"}, (byp != 0) ? exp_raw[r] : exp_conv[r], wbl_o);
            if (r == abort_row) begin
                @(posedge clk_i);
                en_i <= 1'b0;
                repeat (2) @(negedge clk_i);
                compare_value({name, "_abort_wwl"}, 0, {h_wwl_o, j_wwl_o});
                compare_value({name, "_abort_idle"}, 1, idle_o);
                return;
            end
            hi = 0;
            while (j_wwl_o != '0 || h_wwl_o) begin
                hi++;
                @(negedge clk_i);
            end
            compare_value({name, "_high"}, h, hi);
            gap = 0;
            while (j_wwl_o == '0 && !h_wwl_o && !idle_o) begin
                gap++;
                @(negedge clk_i);
            end
            // a new word costs a read strobe and a data cycle
            compare_value({name, "_low"},
                          l + ((r < NUM_SPIN && (r + 1) % PARALLELISM == 0) ? 2 : 0), gap);
        end
        compare_value({name, "_idle"}, 1, idle_o);
    endtask

    initial begin
        int fd;
        int rc;
        int a;
        int s;
        int h;
        int l;
        int byp;
        int abort_row;
        logic [ROW_W-1:0] d;
        logic [ROW_W-1:0] raw;
        string cmd;
        string name;
        string rest;
        rst_n_i = 1'b0;
        mem_we_i = 1'b0;
        mem_addr_i = '0;
        mem_slice_i = '0;
        mem_wdata_i = '0;
        cfg_load_i = 1'b0;
        cycle_per_wwl_high_i = '0;
        cycle_per_wwl_low_i = '0;
        bypass_conv_i = 1'b0;
        en_i = 1'b0;
        start_i = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        compare_value("reset_idle", 1, idle_o);
        compare_value("reset_wwl", 0, {h_wwl_o, j_wwl_o});
        compare_value("reset_wbl", 0, wbl_o);
        fd = $fopen("testbench/cfg_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file testbench/cfg_trace.txt");
            $display("TESTS FAILED");
            $fatal(1, "no trace");
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                rc = $fgets(rest, fd);
            end else if (cmd == "L") begin
                rc = $fscanf(fd, "%d %d %h", a, s, d);
                if (rc != 3) begin
                    reject_trace_line("load");
                end
                write_word(a, s, d);
            end else if (cmd == "E") begin
                rc = $fscanf(fd, "%d %h %h", a, d, raw);
                if (rc != 3) begin
                    reject_trace_line("expected row");
                end
                exp_conv[a] = d;
                exp_raw[a] = raw;
            end else if (cmd == "T") begin
                rc = $fscanf(fd, "%s %d %d %d %d", name, h, l, byp, abort_row);
                if (rc != 5) begin
                    reject_trace_line("test");
                end
                run_sequence(name, h, l, byp, abort_row);
                if (abort_row >= 0) begin
                    run_sequence({name, "_rerun"}, h, l, byp, -1);
                end
            end
        end
        $fclose(fd);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== testbench/cfg_trace.txt ====
# L addr slice data : weight store load, addr 4 is the h word
# E row converted raw : expected bit lines per row, row 8 is h
L 0 0 01234567
L 0 1 89ABCDEF
L 1 0 11111111
L 1 1 13579BDF
L 2 0 02468ACE
L 2 1 FEDCBA98
L 3 0 76543210
L 3 1 C0FFEE00
L 4 0 5A5AA5A5
E 0 1FDB9753 01234567
E 1 0ECA8642 89ABCDEF
E 2 FFFFFFFF 11111111
E 3 FB73EA62 13579BDF
E 4 1D950C84 02468ACE
E 5 2468ACE0 FEDCBA98
E 6 3579BDF1 76543210
E 7 81224411 C0FFEE00
E 8 7C7CC7C7 5A5AA5A5
# T name high low bypass abort_row : one sequence, abort_row -1 runs to the end
T conv_a 3 2 0 -1
T conv_b 1 4 0 -1
T bypass 2 1 1 -1
T abort 2 2 0 3

// ==== src.f ====
common/ising_cfg_pkg.sv
src/step_counter.sv
src/weight_store.sv
analog_cfg/analog_cfg.sv
src/ising_cfg_top.sv
testbench/ising_cfg_assertions.sv
testbench/tb_ising_cfg.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_ising_cfg -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
